// ==== axis_out_pkg.sv ====
`default_nettype none

package axis_out_pkg;

   // Bus and FIFO word width
   localparam int DATA_W = 32;
   // Stream beat width
   localparam int TDATA_W = 8;
   // Beats per word
   localparam int LANES = DATA_W / TDATA_W;
   // Bits needed to pick a lane within a word
   localparam int LANE_W = $clog2(LANES);
   // Write strobe width of the native bus
   localparam int STRB_W = DATA_W / 8;
   // Register address width
   localparam int ADDR_W = 3;

   // FIFO capacity in bytes, as a power of two
   localparam int FIFO_DEPTH_LOG2 = 5;
   localparam int FIFO_BYTES = 1 << FIFO_DEPTH_LOG2;
   // Word address into the storage RAM
   localparam int WORD_ADDR_W = FIFO_DEPTH_LOG2 - LANE_W;
   // Byte level wide enough to hold FIFO_BYTES itself
   localparam int LEVEL_W = FIFO_DEPTH_LOG2 + 1;
   // Above this level a whole word no longer fits
   localparam int PUSH_LIMIT = FIFO_BYTES - LANES;

   // Register map
   typedef enum logic [ADDR_W-1:0] {
      // One-cycle flush on write
      REG_SOFTRESET = 3'd0,
      // Enable in bit 0
      REG_ENABLE    = 3'd1,
      // Lane mask for the next word
      REG_LAST_MASK = 3'd2,
      // Pushes one word on write
      REG_IN        = 3'd3,
      // FULL flag in bit 0
      REG_FULL      = 3'd4,
      // Byte count
      REG_LEVEL     = 3'd5
   } reg_addr_e;

   // Stream FSM states
   typedef enum logic [1:0] {
      ST_IDLE,
      ST_STREAM,
      ST_LAST
   } stream_state_e;

endpackage

`default_nettype wire

// ==== axis_out_fifo_if.sv ====
`default_nettype none

interface axis_out_fifo_if
   import axis_out_pkg::*;
();

   // Word write request from the register block
   logic               push;
   // Byte removal from the stream FSM
   logic               pop;
   // Software reset pulse
   logic               flush;
   // Status kept by the pointer block
   logic               empty;
   logic               full;
   logic [LEVEL_W-1:0] level;
   // Lane of the byte at the head of the FIFO
   logic [LANE_W-1:0]  rd_lane;

   // Pointer side owns the status
   modport ptr (
      input  push, pop, flush,
      output empty, full, level, rd_lane
   );

   // FSM side pops and watches pushes for the last word
   modport fsm (
      input  push, flush, empty, level, rd_lane,
      output pop
   );

endinterface

`default_nettype wire

// ==== axis_out_csr.sv ====
`default_nettype none

module axis_out_csr
   import axis_out_pkg::*;
(
   input  wire                clk_i,
   input  wire                rst_n_i,
   // Native register bus
   input  wire                avalid_i,
   input  wire [ADDR_W-1:0]   addr_i,
   input  wire [DATA_W-1:0]   wdata_i,
   input  wire [STRB_W-1:0]   wstrb_i,
   output logic [DATA_W-1:0]  rdata_o,
   output logic               rvalid_o,
   // FIFO status
   input  wire                full_i,
   input  wire [LEVEL_W-1:0]  level_i,
   // Last-word tracking from the stream FSM
   input  wire                last_done_i,
   input  wire                last_stored_i,
   // Control outputs
   output logic               enable_o,
   output logic [LANES-1:0]   last_mask_o,
   output logic               push_o,
   output logic               flush_o,
   output logic               full_o
);

   reg_addr_e    reg_addr;
   logic         wr_req;
   logic         rd_req;
   logic [DATA_W-1:0] rd_value;

   assign reg_addr = reg_addr_e'(addr_i);
   // Any strobe bit set makes it a write
   assign wr_req = avalid_i && (wstrb_i != '0);
   assign rd_req = avalid_i && (wstrb_i == '0);

   // FULL as software sees it
   // Stays up from the mask write until the masked word has left the FIFO
   assign full_o = full_i || (last_mask_o != '0);

   // The masked word itself must get in, so the push gate ignores the mask
   // Only a stored last word or a full FIFO blocks it
   assign push_o = wr_req && (reg_addr == REG_IN) && !full_i && !last_stored_i;
   assign flush_o = wr_req && (reg_addr == REG_SOFTRESET);

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         enable_o <= 1'b0;
      end else if (wr_req && (reg_addr == REG_ENABLE)) begin
         enable_o <= wdata_i[0];
      end
   end

   // Mask for the final word of a frame
   // A new write wins over a clear in the same cycle
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         last_mask_o <= '0;
      end else if (flush_o) begin
         last_mask_o <= '0;
      end else if (wr_req && (reg_addr == REG_LAST_MASK)) begin
         last_mask_o <= wdata_i[LANES-1:0];
      end else if (last_done_i) begin
         last_mask_o <= '0;
      end
   end

   // Write-only and unmapped addresses read as zero
   always_comb begin
      rd_value = '0;
      case (reg_addr)
         REG_ENABLE: rd_value = DATA_W'(enable_o);
         REG_FULL:   rd_value = DATA_W'(full_o);
         REG_LEVEL:  rd_value = DATA_W'(level_i);
         default:    rd_value = '0;
      endcase
   end

   // Read data one cycle after the request
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rvalid_o <= 1'b0;
      end else begin
         rvalid_o <= rd_req;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rd_req) begin
         rdata_o <= rd_value;
      end
   end

endmodule

`default_nettype wire

// ==== axis_out_fifo_ptr.sv ====
`default_nettype none

module axis_out_fifo_ptr
   import axis_out_pkg::*;
(
   input  wire                     clk_i,
   input  wire                     rst_n_i,
   axis_out_fifo_if.ptr            fifo,
   // Storage RAM control
   output logic                    ram_w_en_o,
   output logic [WORD_ADDR_W-1:0]  ram_w_addr_o,
   output logic [WORD_ADDR_W-1:0]  ram_r_addr_o
);

   // Words go in whole, bytes come out one at a time
   logic [WORD_ADDR_W-1:0]     wr_ptr_q;
   logic [FIFO_DEPTH_LOG2-1:0] rd_ptr_q;
   logic [FIFO_DEPTH_LOG2-1:0] rd_ptr_d;
   logic [LEVEL_W-1:0]         level_q;
   logic [LEVEL_W-1:0]         level_popped;
   logic [LEVEL_W-1:0]         level_d;
   // Head word was written in the same cycle it was read
   logic                       stale_q;

   assign rd_ptr_d = rd_ptr_q + FIFO_DEPTH_LOG2'(fifo.pop);

   // Push adds a word, pop removes a byte, both may happen together
   assign level_popped = level_q - LEVEL_W'(fifo.pop);
   assign level_d = fifo.push ? level_popped + LEVEL_W'(LANES) : level_popped;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         level_q  <= '0;
         stale_q  <= 1'b0;
      end else if (fifo.flush) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         level_q  <= '0;
         stale_q  <= 1'b0;
      end else begin
         if (fifo.push) begin
            wr_ptr_q <= wr_ptr_q + WORD_ADDR_W'(1);
         end
         rd_ptr_q <= rd_ptr_d;
         level_q  <= level_d;
         // Pushing into a drained FIFO hits the word being read
         // RAM output is old data for one more cycle
         stale_q  <= fifo.push && (level_popped == '0);
      end
   end

   assign ram_w_en_o   = fifo.push;
   assign ram_w_addr_o = wr_ptr_q;
   // Look ahead on a pop so the next word is on the RAM output in time
   assign ram_r_addr_o = rd_ptr_d[FIFO_DEPTH_LOG2-1:LANE_W];

   // Hide the head byte until the RAM output is valid
   assign fifo.empty   = (level_q == '0) || stale_q;
   assign fifo.full    = level_q > LEVEL_W'(PUSH_LIMIT);
   assign fifo.level   = level_q;
   assign fifo.rd_lane = rd_ptr_q[LANE_W-1:0];

endmodule

`default_nettype wire

// ==== axis_out_ram.sv ====
`default_nettype none

module axis_out_ram
   import axis_out_pkg::*;
(
   input  wire                    clk_i,
   // Write port
   input  wire                    w_en_i,
   input  wire [WORD_ADDR_W-1:0]  w_addr_i,
   input  wire [DATA_W-1:0]       w_data_i,
   // Registered read port
   input  wire [WORD_ADDR_W-1:0]  r_addr_i,
   output logic [DATA_W-1:0]      r_data_o
);

   // One word per FIFO slot
   logic [DATA_W-1:0] mem [(1 << WORD_ADDR_W)];

   always_ff @(posedge clk_i) begin
      if (w_en_i) begin
         mem[w_addr_i] <= w_data_i;
      end
   end

   // Reads every cycle
   // Same-address write shows up one cycle later
   always_ff @(posedge clk_i) begin
      r_data_o <= mem[r_addr_i];
   end

endmodule

`default_nettype wire

// ==== axis_out_stream_fsm.sv ====
`default_nettype none

module axis_out_stream_fsm
   import axis_out_pkg::*;
(
   input  wire                  clk_i,
   input  wire                  rst_n_i,
   input  wire                  enable_i,
   input  wire [LANES-1:0]      last_mask_i,
   input  wire                  tready_i,
   axis_out_fifo_if.fsm         fifo,
   // Head word from the RAM
   input  wire [DATA_W-1:0]     ram_r_data_i,
   // AXI-Stream master
   output logic [TDATA_W-1:0]   tdata_o,
   output logic                 tvalid_o,
   output logic                 tlast_o,
   // Last-word tracking for the register block
   output logic                 last_stored_o,
   output logic                 last_done_o
);

   stream_state_e      state_q;
   stream_state_e      state_d;
   logic               last_stored_q;
   logic               out_free;
   logic               pop;
   logic [TDATA_W-1:0] lane_byte;
   logic               in_last_word;
   logic [LANES-1:0]   mask_above;
   logic               keep_lane;
   logic               last_lane;
   logic               final_lane;

   // Output register can take a byte when empty or being consumed
   assign out_free = !tvalid_o || tready_i;
   assign pop = enable_i && !fifo.empty && out_free && !fifo.flush;
   assign fifo.pop = pop;

   // Byte at the head of the FIFO
   assign lane_byte = ram_r_data_i[fifo.rd_lane*TDATA_W +: TDATA_W];

   // Only the masked word is left once the level drops to one word
   assign in_last_word = (state_q == ST_LAST) && (fifo.level <= LEVEL_W'(LANES));
   // Set lanes above the current one
   assign mask_above = (last_mask_i >> fifo.rd_lane) >> 1;
   // Clear lanes of the last word are popped without a beat
   assign keep_lane = !in_last_word || last_mask_i[fifo.rd_lane];
   assign last_lane = in_last_word && last_mask_i[fifo.rd_lane] && (mask_above == '0);
   // Top lane of the last word whether or not it is a beat
   assign final_lane = in_last_word && (fifo.rd_lane == LANE_W'(LANES - 1));

   // Frame is done once its whole word has left the FIFO
   assign last_done_o   = pop && final_lane;
   assign last_stored_o = last_stored_q;

   // A word pushed under a nonzero mask closes the frame
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         last_stored_q <= 1'b0;
      end else if (fifo.flush || last_done_o) begin
         last_stored_q <= 1'b0;
      end else if (fifo.push && (last_mask_i != '0)) begin
         last_stored_q <= 1'b1;
      end
   end

   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_IDLE: begin
            if (last_stored_q) begin
               state_d = ST_LAST;
            end else if (!fifo.empty) begin
               state_d = ST_STREAM;
            end
         end
         ST_STREAM: begin
            if (last_stored_q) begin
               state_d = ST_LAST;
            end else if (fifo.empty) begin
               state_d = ST_IDLE;
            end
         end
         ST_LAST: begin
            if (last_done_o) begin
               state_d = ST_IDLE;
            end
         end
         default: state_d = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= ST_IDLE;
      end else if (fifo.flush) begin
         state_q <= ST_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // Beat control holds while the sink stalls
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         tvalid_o <= 1'b0;
         tlast_o  <= 1'b0;
      end else if (fifo.flush) begin
         tvalid_o <= 1'b0;
         tlast_o  <= 1'b0;
      end else if (pop) begin
         tvalid_o <= keep_lane;
         tlast_o  <= last_lane;
      end else if (tready_i) begin
         tvalid_o <= 1'b0;
         tlast_o  <= 1'b0;
      end
   end

   // Beat payload
   always_ff @(posedge clk_i) begin
      if (pop) begin
         tdata_o <= lane_byte;
      end
   end

endmodule

`default_nettype wire

// ==== axis_out_top.sv ====
`default_nettype none

module axis_out_top
   import axis_out_pkg::*;
(
   input  wire                 clk_i,
   input  wire                 rst_n_i,
   // Native register bus
   input  wire                 avalid_i,
   input  wire [ADDR_W-1:0]    addr_i,
   input  wire [DATA_W-1:0]    wdata_i,
   input  wire [STRB_W-1:0]    wstrb_i,
   output wire [DATA_W-1:0]    rdata_o,
   output wire                 rvalid_o,
   // AXI-Stream master
   input  wire                 tready_i,
   output wire [TDATA_W-1:0]   tdata_o,
   output wire                 tvalid_o,
   output wire                 tlast_o
);

   wire                   push;
   wire                   flush;
   wire                   enable;
   wire [LANES-1:0]       last_mask;
   wire                   last_done;
   wire                   last_stored;
   wire                   ram_w_en;
   wire [WORD_ADDR_W-1:0] ram_w_addr;
   wire [WORD_ADDR_W-1:0] ram_r_addr;
   wire [DATA_W-1:0]      ram_r_data;

   axis_out_fifo_if fifo_bus ();

   // Register block drives the FIFO requests
   assign fifo_bus.push  = push;
   assign fifo_bus.flush = flush;

   axis_out_csr csr_i (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .avalid_i      (avalid_i),
      .addr_i        (addr_i),
      .wdata_i       (wdata_i),
      .wstrb_i       (wstrb_i),
      .rdata_o       (rdata_o),
      .rvalid_o      (rvalid_o),
      .full_i        (fifo_bus.full),
      .level_i       (fifo_bus.level),
      .last_done_i   (last_done),
      .last_stored_i (last_stored),
      .enable_o      (enable),
      .last_mask_o   (last_mask),
      .push_o        (push),
      .flush_o       (flush),
      // FULL is only seen through the register bus
      .full_o        ()
   );

   axis_out_fifo_ptr fifo_ptr_i (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .fifo         (fifo_bus.ptr),
      .ram_w_en_o   (ram_w_en),
      .ram_w_addr_o (ram_w_addr),
      .ram_r_addr_o (ram_r_addr)
   );

   // Bus write data goes straight into storage
   axis_out_ram ram_i (
      .clk_i    (clk_i),
      .w_en_i   (ram_w_en),
      .w_addr_i (ram_w_addr),
      .w_data_i (wdata_i),
      .r_addr_i (ram_r_addr),
      .r_data_o (ram_r_data)
   );

   axis_out_stream_fsm stream_fsm_i (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .enable_i      (enable),
      .last_mask_i   (last_mask),
      .tready_i      (tready_i),
      .fifo          (fifo_bus.fsm),
      .ram_r_data_i  (ram_r_data),
      .tdata_o       (tdata_o),
      .tvalid_o      (tvalid_o),
      .tlast_o       (tlast_o),
      .last_stored_o (last_stored),
      .last_done_o   (last_done)
   );

endmodule

`default_nettype wire

// ==== tb_axis_out.sv ====
`default_nettype none

module tb_axis_out
   import axis_out_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   // Wait loop bounds in clock cycles and bus reads
   localparam int BEAT_TIMEOUT = 500;
   localparam int POLL_LIMIT = 50;

   // Row operations
   typedef enum {
      OP_WRITE,
      OP_READ,
      OP_POLL,
      OP_BEATS,
      OP_IDLE,
      OP_READY
   } tb_op_e;

   logic               clk_i;
   logic               rst_n_i;
   logic               avalid_i;
   logic [ADDR_W-1:0]  addr_i;
   logic [DATA_W-1:0]  wdata_i;
   logic [STRB_W-1:0]  wstrb_i;
   logic               tready_i;
   wire [DATA_W-1:0]   rdata_o;
   wire                rvalid_o;
   wire [TDATA_W-1:0]  tdata_o;
   wire                tvalid_o;
   wire                tlast_o;

   // Stimulus table with one entry per row in each queue
   string              row_name[$];
   tb_op_e             row_op[$];
   reg_addr_e          row_addr[$];
   logic [DATA_W-1:0]  row_data[$];
   bit                 row_take[$];

   // Expected beats as {tlast, tdata} with the oldest first
   logic [TDATA_W:0]   exp_q[$];
   logic [TDATA_W:0]   beat_exp;
   logic [LANES-1:0]   model_mask;
   string              cur_name;
   bit                 ready_random;
   integer             seed;

   axis_out_top dut_i (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .avalid_i (avalid_i),
      .addr_i   (addr_i),
      .wdata_i  (wdata_i),
      .wstrb_i  (wstrb_i),
      .rdata_o  (rdata_o),
      .rvalid_o (rvalid_o),
      .tready_i (tready_i),
      .tdata_o  (tdata_o),
      .tvalid_o (tvalid_o),
      .tlast_o  (tlast_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #50 clk_i = ~clk_i;
   end

   task automatic abort_run();
      $display("ERRORS FOUND");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic check_data(input string name, input logic [TDATA_W-1:0] exp,
                             input logic [TDATA_W-1:0] act);
      if (exp !== act) begin
         $display("FAIL %s: tdata expected %02h, got %02h", name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_last(input string name, input logic exp, input logic act);
      if (exp !== act) begin
         $display("FAIL %s: tlast expected %0b, got %0b", name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_valid(input string name, input logic exp, input logic act);
      if (exp !== act) begin
         $display("FAIL %s: tvalid expected %0b, got %0b", name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_rvalid(input string name, input logic exp, input logic act);
      if (exp !== act) begin
         $display("FAIL %s: rvalid expected %0b, got %0b", name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_reg(input string name, input logic [DATA_W-1:0] exp,
                            input logic [DATA_W-1:0] act);
      if (exp !== act) begin
         $display("FAIL %s: register expected %08h, got %08h", name, exp, act);
         abort_run();
      end
   endtask

   // Every cycle of the main process goes through here
   // Random tready is drawn on the falling edge together with the bus inputs
   task automatic next_cycle();
      integer rnd;
      @(negedge clk_i);
      if (ready_random) begin
         rnd = $random(seed);
         tready_i = rnd[0];
      end
   endtask

   task automatic bus_write(input reg_addr_e addr, input logic [DATA_W-1:0] data);
      avalid_i = 1'b1;
      addr_i   = addr;
      wdata_i  = data;
      wstrb_i  = '1;
      next_cycle();
      avalid_i = 1'b0;
      wstrb_i  = '0;
      // A write never returns read data
      check_rvalid(cur_name, 1'b0, rvalid_o);
   endtask

   // Read data follows the request by exactly one cycle
   task automatic bus_read(input reg_addr_e addr, output logic [DATA_W-1:0] data);
      avalid_i = 1'b1;
      addr_i   = addr;
      wstrb_i  = '0;
      next_cycle();
      avalid_i = 1'b0;
      check_rvalid(cur_name, 1'b1, rvalid_o);
      data = rdata_o;
      next_cycle();
      check_rvalid(cur_name, 1'b0, rvalid_o);
   endtask

   // Lanes go out low byte first
   // Under a mask only set lanes are sent
   // The highest set lane carries tlast
   task automatic queue_word(input logic [DATA_W-1:0] word, input logic [LANES-1:0] mask);
      int top;
      top = LANES - 1;
      for (int i = 0; i < LANES; i++) begin
         if (mask[i]) begin
            top = i;
         end
      end
      for (int lane = 0; lane < LANES; lane++) begin
         if (mask == '0 || mask[lane]) begin
            exp_q.push_back({mask != '0 && lane == top, word[lane*TDATA_W +: TDATA_W]});
         end
      end
   endtask

   // Reference side of a register write
   task automatic model_write(input reg_addr_e addr, input logic [DATA_W-1:0] data,
                              input bit take);
      case (addr)
         REG_SOFTRESET: begin
            exp_q.delete();
            model_mask = '0;
         end
         REG_LAST_MASK: model_mask = data[LANES-1:0];
         REG_IN: begin
            if (take) begin
               queue_word(data, model_mask);
               model_mask = '0;
            end
         end
         default: ;
      endcase
   endtask

   task automatic add_row(input string name, input tb_op_e op, input reg_addr_e addr,
                          input logic [DATA_W-1:0] data, input bit take);
      row_name.push_back(name);
      row_op.push_back(op);
      row_addr.push_back(addr);
      row_data.push_back(data);
      row_take.push_back(take);
   endtask

   task automatic build_table();
      // Two plain words give eight beats
      add_row("b1 enable", OP_WRITE, REG_ENABLE, 32'h1, 1'b1);
      add_row("b1 word0", OP_WRITE, REG_IN, 32'h4433_2211, 1'b1);
      add_row("b1 word1", OP_WRITE, REG_IN, 32'h8877_6655, 1'b1);
      add_row("b1 drain", OP_BEATS, REG_IN, 32'h0, 1'b0);
      add_row("b1 level", OP_READ, REG_LEVEL, 32'h0, 1'b0);
      // Mask 0011 on a single word
      add_row("b2 mask", OP_WRITE, REG_LAST_MASK, 32'h3, 1'b1);
      add_row("b2 full set", OP_READ, REG_FULL, 32'h1, 1'b0);
      add_row("b2 word", OP_WRITE, REG_IN, 32'hddcc_bbaa, 1'b1);
      add_row("b2 drain", OP_BEATS, REG_IN, 32'h0, 1'b0);
      add_row("b2 full clear", OP_POLL, REG_FULL, 32'h0, 1'b0);
      add_row("b2 level", OP_READ, REG_LEVEL, 32'h0, 1'b0);
      // Disabled output holds the data back
      add_row("b3 disable", OP_WRITE, REG_ENABLE, 32'h0, 1'b1);
      add_row("b3 word0", OP_WRITE, REG_IN, 32'h0403_0201, 1'b1);
      add_row("b3 word1", OP_WRITE, REG_IN, 32'h0807_0605, 1'b1);
      add_row("b3 quiet", OP_IDLE, REG_IN, 32'd10, 1'b0);
      add_row("b3 level", OP_READ, REG_LEVEL, 32'd8, 1'b0);
      add_row("b3 enable off", OP_READ, REG_ENABLE, 32'h0, 1'b0);
      add_row("b3 enable", OP_WRITE, REG_ENABLE, 32'h1, 1'b1);
      add_row("b3 drain", OP_BEATS, REG_IN, 32'h0, 1'b0);
      add_row("b3 level empty", OP_POLL, REG_LEVEL, 32'h0, 1'b0);
      // Fill all eight words and have the ninth refused
      add_row("b4 disable", OP_WRITE, REG_ENABLE, 32'h0, 1'b1);
      for (int w = 0; w < 8; w++) begin
         add_row("b4 fill", OP_WRITE, REG_IN, 32'h3020_1000 + 32'h0101_0101 * w, 1'b1);
      end
      add_row("b4 full", OP_READ, REG_FULL, 32'h1, 1'b0);
      add_row("b4 overflow", OP_WRITE, REG_IN, 32'hdead_beef, 1'b0);
      add_row("b4 level", OP_READ, REG_LEVEL, 32'd32, 1'b0);
      add_row("b4 enable", OP_WRITE, REG_ENABLE, 32'h1, 1'b1);
      add_row("b4 drain", OP_BEATS, REG_IN, 32'h0, 1'b0);
      add_row("b4 no extra", OP_IDLE, REG_IN, 32'd10, 1'b0);
      add_row("b4 level empty", OP_READ, REG_LEVEL, 32'h0, 1'b0);
      add_row("b4 full clear", OP_READ, REG_FULL, 32'h0, 1'b0);
      // Back-pressure on a masked frame
      add_row("b5 random ready", OP_READY, REG_IN, 32'd2, 1'b0);
      add_row("b5 word", OP_WRITE, REG_IN, 32'h1312_1110, 1'b1);
      add_row("b5 mask", OP_WRITE, REG_LAST_MASK, 32'h7, 1'b1);
      add_row("b5 last word", OP_WRITE, REG_IN, 32'h1716_1514, 1'b1);
      add_row("b5 drain", OP_BEATS, REG_IN, 32'h0, 1'b0);
      add_row("b5 ready high", OP_READY, REG_IN, 32'd1, 1'b0);
      add_row("b5 full clear", OP_POLL, REG_FULL, 32'h0, 1'b0);
      // Flush with a beat stalled in the output register
      add_row("b6 stall", OP_READY, REG_IN, 32'd0, 1'b0);
      add_row("b6 word", OP_WRITE, REG_IN, 32'h2322_2120, 1'b1);
      add_row("b6 mask", OP_WRITE, REG_LAST_MASK, 32'hf, 1'b1);
      add_row("b6 full set", OP_READ, REG_FULL, 32'h1, 1'b0);
      add_row("b6 softreset", OP_WRITE, REG_SOFTRESET, 32'h1, 1'b1);
      add_row("b6 level", OP_READ, REG_LEVEL, 32'h0, 1'b0);
      add_row("b6 full", OP_READ, REG_FULL, 32'h0, 1'b0);
      add_row("b6 quiet", OP_IDLE, REG_IN, 32'd8, 1'b0);
      add_row("b6 ready high", OP_READY, REG_IN, 32'd1, 1'b0);
      add_row("b6 new mask", OP_WRITE, REG_LAST_MASK, 32'hf, 1'b1);
      add_row("b6 new word", OP_WRITE, REG_IN, 32'h2726_2524, 1'b1);
      add_row("b6 drain", OP_BEATS, REG_IN, 32'h0, 1'b0);
      add_row("b6 full clear", OP_POLL, REG_FULL, 32'h0, 1'b0);
   endtask

   task automatic run_row(input int r);
      logic [DATA_W-1:0] value;
      int n;
      cur_name = row_name[r];
      case (row_op[r])
         OP_WRITE: begin
            model_write(row_addr[r], row_data[r], row_take[r]);
            bus_write(row_addr[r], row_data[r]);
         end
         OP_READ: begin
            bus_read(row_addr[r], value);
            check_reg(cur_name, row_data[r], value);
         end
         OP_POLL: begin
            bus_read(row_addr[r], value);
            n = 0;
            while (value !== row_data[r] && n < POLL_LIMIT) begin
               bus_read(row_addr[r], value);
               n++;
            end
            if (value !== row_data[r]) begin
               $display("%s: register %s never read %0h before the timeout",
                        cur_name, row_addr[r].name(), row_data[r]);
               abort_run();
            end
         end
         OP_BEATS: begin
            n = 0;
            while (exp_q.size() != 0 && n < BEAT_TIMEOUT) begin
               next_cycle();
               n++;
            end
            if (exp_q.size() != 0) begin
               $display("%s: %0d expected stream beats never arrived", cur_name, exp_q.size());
               abort_run();
            end
         end
         OP_IDLE: begin
            for (n = 0; n < int'(row_data[r]); n++) begin
               check_valid(cur_name, 1'b0, tvalid_o);
               next_cycle();
            end
         end
         OP_READY: begin
            // 0 and 1 hold tready_i
            // 2 draws it every cycle
            ready_random = (row_data[r] == 32'd2);
            if (!ready_random) begin
               tready_i = row_data[r][0];
            end
         end
         default: ;
      endcase
   endtask

   // Stream monitor pops one reference entry per completed beat
   always @(posedge clk_i) begin
      if (rst_n_i && tvalid_o && tready_i) begin
         if (exp_q.size() == 0) begin
            $display("%s: a beat appeared on the stream with no byte expected", cur_name);
            abort_run();
         end else begin
            beat_exp = exp_q.pop_front();
            check_data(cur_name, beat_exp[TDATA_W-1:0], tdata_o);
            check_last(cur_name, beat_exp[TDATA_W], tlast_o);
         end
      end
   end

   initial begin
      rst_n_i      = 1'b0;
      avalid_i     = 1'b0;
      addr_i       = '0;
      wdata_i      = '0;
      wstrb_i      = '0;
      tready_i     = 1'b1;
      model_mask   = '0;
      ready_random = 1'b0;
      cur_name     = "reset";
      seed         = 32'h8332_4732;
      build_table();
      repeat (4) @(posedge clk_i);
      @(negedge clk_i);
      rst_n_i = 1'b1;
      next_cycle();
      for (int r = 0; r < row_name.size(); r++) begin
         run_row(r);
      end
      $display("NO ERRORS");
      $finish;
   end

endmodule

`default_nettype wire

// ==== files.f ====
axis_out_pkg.sv
axis_out_fifo_if.sv
axis_out_csr.sv
axis_out_fifo_ptr.sv
axis_out_ram.sv
axis_out_stream_fsm.sv
axis_out_top.sv
tb_axis_out.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f files.f \
   --top-module tb_axis_out -o sim_axis_out > build.log 2>&1 \
   || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/sim_axis_out > sim.log 2>&1

# Any error or timeout in the testbench leaves its fail message in the log
grep -q "ERRORS FOUND" sim.log \
   && { echo "Simulation failed, see sim.log"; exit 1; } \
   || { grep -q "NO ERRORS" sim.log && echo "Simulation passed" && exit 0; } \
   || { echo "Simulation ended without a result, see sim.log"; exit 1; }
